//--- hdl/gcu_bus_pkg.sv
package gcu_bus_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  reg_idx_t;
    typedef logic [8:0]  pos_t;

    typedef enum logic [2:0] {
        OP_SELECT_REG = 3'd0,
        OP_WRITE_REG  = 3'd1,
        OP_SET_PTR    = 3'd2,
        OP_WRITE_RAM  = 3'd3,
        OP_READ_RAM_H = 3'd4,
        OP_READ_RAM_L = 3'd5
    } gcu_op_e;

    typedef struct packed {
        gcu_op_e op;
        word_t   data;
    } gcu_cmd_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } gcu_rsp_t;

    // bit 7 survives the mask so 0x8x indices alias 0x0x
    localparam reg_idx_t REG_IDX_MASK  = 8'h8F;
    localparam reg_idx_t REG_IRQ_ACK_A = 8'h0E;
    localparam reg_idx_t REG_IRQ_ACK_B = 8'h0F;
    localparam reg_idx_t REG_IRQ_ACK_C = 8'h8F;

    typedef struct packed {
        word_t bg_x;
        word_t bg_y;
        word_t fg_x;
        word_t fg_y;
        word_t txt_x;
        word_t txt_y;
        word_t spr_x;
        word_t spr_y;
    } scroll_regs_t;

    // line on which the vertical interrupt fires
    localparam pos_t VINT_LINE = 9'h0E6;

endpackage

//--- hdl/vram_map_pkg.sv
package vram_map_pkg;

    localparam int VRAM_AW   = 13;
    localparam int LAYER_AW  = 11;
    localparam int SPRITE_AW = 10;

    typedef logic [VRAM_AW-1:0]   vram_addr_t;
    typedef logic [LAYER_AW-1:0]  layer_addr_t;
    typedef logic [SPRITE_AW-1:0] sprite_addr_t;

    // region bases inside main VRAM
    localparam vram_addr_t LAYER0_BASE = 13'h0000;
    localparam vram_addr_t LAYER1_BASE = 13'h0800;
    localparam vram_addr_t LAYER2_BASE = 13'h1000;
    localparam vram_addr_t SPRITE_BASE = 13'h1800;

    localparam int LAYER_WORDS  = 2048;
    localparam int SPRITE_WORDS = 1024;

endpackage

//--- hdl/gcu_dpram.sv
`timescale 1ns/1ps

module gcu_dpram #(
    parameter int AW = 10,
    parameter int DW = 16
) (
    input  logic          CLK96,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  logic [DW-1:0] wr_data,
    input  logic [AW-1:0] rd_addr,
    output logic [DW-1:0] rd_data
);

    logic [DW-1:0] mem [2**AW];

    // read is registered, data one cycle after the address
    always_ff @(posedge CLK96) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

//--- hdl/gcu_bus_ctrl.sv
`timescale 1ns/1ps

module gcu_bus_ctrl
    import gcu_bus_pkg::*;
    import vram_map_pkg::*;
(
    input  logic         CLK96,
    input  logic         RESET96,
    input  gcu_cmd_t     cmd,
    input  logic         cmd_valid,
    output logic         cmd_ready,
    output gcu_rsp_t     rsp,
    output scroll_regs_t scroll,
    output reg_idx_t     sel_reg,
    output logic         wr_en,
    output vram_addr_t   wr_addr,
    output word_t        wr_data,
    output vram_addr_t   rd_addr,
    input  word_t        rd_data
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ_WAIT,
        READ_DONE
    } state_e;

    state_e state;
    word_t  ram_ptr;
    logic   ready_q;
    logic   rsp_valid;
    word_t  rsp_data;
    logic   accept;

    assign accept    = cmd_valid && ready_q;
    assign cmd_ready = ready_q;

    // ram write goes out the cycle after acceptance
    assign wr_en   = (state == WRITE);
    assign wr_addr = ram_ptr[VRAM_AW-1:0];
    assign rsp     = '{valid: rsp_valid, data: rsp_data};

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state     <= IDLE;
            ready_q   <= 1'b1;
            sel_reg   <= '1;
            scroll    <= '0;
            ram_ptr   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        case (cmd.op)
                            OP_SELECT_REG: sel_reg <= cmd.data[7:0] & REG_IDX_MASK;
                            OP_WRITE_REG: begin
                                // only scroll indices, bit 7 ignored
                                if (sel_reg[6:3] == 4'h0) begin
                                    case (sel_reg[2:0])
                                        3'd0: scroll.bg_x  <= cmd.data;
                                        3'd1: scroll.bg_y  <= cmd.data;
                                        3'd2: scroll.fg_x  <= cmd.data;
                                        3'd3: scroll.fg_y  <= cmd.data;
                                        3'd4: scroll.txt_x <= cmd.data;
                                        3'd5: scroll.txt_y <= cmd.data;
                                        3'd6: scroll.spr_x <= cmd.data;
                                        3'd7: scroll.spr_y <= cmd.data;
                                    endcase
                                end
                            end
                            OP_SET_PTR: ram_ptr <= cmd.data;
                            OP_WRITE_RAM: begin
                                state   <= WRITE;
                                ready_q <= 1'b0;
                            end
                            OP_READ_RAM_H, OP_READ_RAM_L: begin
                                state   <= READ_WAIT;
                                ready_q <= 1'b0;
                            end
                            default: ;
                        endcase
                    end
                end
                WRITE: begin
                    ram_ptr <= ram_ptr + 1'b1;
                    state   <= IDLE;
                    ready_q <= 1'b1;
                end
                // ram output lands during READ_DONE
                READ_WAIT: state <= READ_DONE;
                READ_DONE: begin
                    if (rsp_valid) begin
                        rsp_valid <= 1'b0;
                        state     <= IDLE;
                        ready_q   <= 1'b1;
                    end else begin
                        rsp_valid <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge CLK96) begin
        if (accept) begin
            wr_data <= cmd.data;
            rd_addr <= ram_ptr[VRAM_AW-1:0] + vram_addr_t'(cmd.op == OP_READ_RAM_L);
        end
        if (state == READ_DONE && !rsp_valid) begin
            rsp_data <= rd_data;
        end
    end

    // registered ready must track the sequencer
    assert property (@(posedge CLK96) disable iff (RESET96)
        (state != IDLE) |-> !cmd_ready);

    assert property (@(posedge CLK96) disable iff (RESET96)
        rsp.valid |=> !rsp.valid);

endmodule

//--- hdl/vram_banks.sv
`timescale 1ns/1ps

module vram_banks
    import gcu_bus_pkg::*;
    import vram_map_pkg::*;
(
    input  logic         CLK96,
    input  logic         wr_en,
    input  vram_addr_t   wr_addr,
    input  word_t        wr_data,
    input  vram_addr_t   rd_addr,
    output word_t        rd_data,
    input  layer_addr_t  scr0_addr,
    input  layer_addr_t  scr1_addr,
    input  layer_addr_t  scr2_addr,
    output word_t        scr0_data,
    output word_t        scr1_data,
    output word_t        scr2_data,
    input  sprite_addr_t spr_addr,
    output word_t        spr_data
);

    logic l0_we;
    logic l1_we;
    logic l2_we;
    logic spr_we;

    function automatic logic in_region(vram_addr_t addr, vram_addr_t base, int words);
        return (int'(addr) >= int'(base)) && (int'(addr) < int'(base) + words);
    endfunction

    // mirror enables follow the main write
    assign l0_we  = wr_en && in_region(wr_addr, LAYER0_BASE, LAYER_WORDS);
    assign l1_we  = wr_en && in_region(wr_addr, LAYER1_BASE, LAYER_WORDS);
    assign l2_we  = wr_en && in_region(wr_addr, LAYER2_BASE, LAYER_WORDS);
    assign spr_we = wr_en && in_region(wr_addr, SPRITE_BASE, SPRITE_WORDS);

    gcu_dpram #(.AW(VRAM_AW), .DW(16)) u_main (
        .CLK96(CLK96), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    gcu_dpram #(.AW(LAYER_AW), .DW(16)) u_layer0 (
        .CLK96(CLK96), .wr_en(l0_we), .wr_addr(wr_addr[LAYER_AW-1:0]), .wr_data(wr_data),
        .rd_addr(scr0_addr), .rd_data(scr0_data)
    );

    gcu_dpram #(.AW(LAYER_AW), .DW(16)) u_layer1 (
        .CLK96(CLK96), .wr_en(l1_we), .wr_addr(wr_addr[LAYER_AW-1:0]), .wr_data(wr_data),
        .rd_addr(scr1_addr), .rd_data(scr1_data)
    );

    gcu_dpram #(.AW(LAYER_AW), .DW(16)) u_layer2 (
        .CLK96(CLK96), .wr_en(l2_we), .wr_addr(wr_addr[LAYER_AW-1:0]), .wr_data(wr_data),
        .rd_addr(scr2_addr), .rd_data(scr2_data)
    );

    gcu_dpram #(.AW(SPRITE_AW), .DW(16)) u_sprite (
        .CLK96(CLK96), .wr_en(spr_we), .wr_addr(wr_addr[SPRITE_AW-1:0]), .wr_data(wr_data),
        .rd_addr(spr_addr), .rd_data(spr_data)
    );

    // regions must never overlap
    assert property (@(posedge CLK96) $onehot0({l0_we, l1_we, l2_we, spr_we}));

endmodule

//--- hdl/video_timing.sv
`timescale 1ns/1ps

module video_timing
    import gcu_bus_pkg::*;
(
    input  logic     CLK96,
    input  logic     RESET96,
    input  pos_t     h,
    input  pos_t     v,
    input  pos_t     hs_start,
    input  pos_t     hs_end,
    input  pos_t     vs_start,
    input  pos_t     vs_end,
    input  reg_idx_t sel_reg,
    output logic     hsync,
    output logic     vsync,
    output logic     fblank,
    output logic     vint
);

    logic h_in;
    logic v_in;
    logic irq_active;

    // horizontal window excludes both edges, vertical includes them
    assign h_in = (h > hs_start) && (h < hs_end);
    assign v_in = (v >= vs_start) && (v <= vs_end);

    assign irq_active = (v == VINT_LINE) || (sel_reg == REG_IRQ_ACK_A) ||
                        (sel_reg == REG_IRQ_ACK_B) || (sel_reg == REG_IRQ_ACK_C);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            fblank <= 1'b1;
            vint   <= 1'b0;
        end else begin
            hsync  <= !h_in;
            vsync  <= !v_in;
            fblank <= !(h_in || v_in);
            // active low interrupt line
            vint   <= !irq_active;
        end
    end

endmodule

//--- hdl/gcu_top.sv
`timescale 1ns/1ps

module gcu_top
    import gcu_bus_pkg::*;
    import vram_map_pkg::*;
(
    input  logic         CLK96,
    input  logic         RESET96,
    input  gcu_cmd_t     cmd,
    input  logic         cmd_valid,
    output logic         cmd_ready,
    output gcu_rsp_t     rsp,
    output scroll_regs_t scroll,
    input  layer_addr_t  scr0_addr,
    input  layer_addr_t  scr1_addr,
    input  layer_addr_t  scr2_addr,
    output word_t        scr0_data,
    output word_t        scr1_data,
    output word_t        scr2_data,
    input  sprite_addr_t spr_addr,
    output word_t        spr_data,
    input  pos_t         h,
    input  pos_t         v,
    input  pos_t         hs_start,
    input  pos_t         hs_end,
    input  pos_t         vs_start,
    input  pos_t         vs_end,
    output logic         hsync,
    output logic         vsync,
    output logic         fblank,
    output logic         vint
);

    reg_idx_t   sel_reg;
    logic       wr_en;
    vram_addr_t wr_addr;
    word_t      wr_data;
    vram_addr_t rd_addr;
    word_t      rd_data;

    gcu_bus_ctrl u_bus_ctrl (
        .CLK96(CLK96), .RESET96(RESET96),
        .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .rsp(rsp), .scroll(scroll), .sel_reg(sel_reg),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    vram_banks u_vram_banks (
        .CLK96(CLK96),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data),
        .scr0_addr(scr0_addr), .scr1_addr(scr1_addr), .scr2_addr(scr2_addr),
        .scr0_data(scr0_data), .scr1_data(scr1_data), .scr2_data(scr2_data),
        .spr_addr(spr_addr), .spr_data(spr_data)
    );

    video_timing u_video_timing (
        .CLK96(CLK96), .RESET96(RESET96),
        .h(h), .v(v),
        .hs_start(hs_start), .hs_end(hs_end), .vs_start(vs_start), .vs_end(vs_end),
        .sel_reg(sel_reg),
        .hsync(hsync), .vsync(vsync), .fblank(fblank), .vint(vint)
    );

endmodule

//--- dv/gcu_checker.sv
`timescale 1ns/1ps

module gcu_checker
    import gcu_bus_pkg::*;
(
    input  logic         CLK96,
    input  logic         RESET96,
    input  gcu_cmd_t     cmd,
    input  logic         cmd_valid,
    input  logic         cmd_ready,
    input  gcu_rsp_t     rsp,
    input  scroll_regs_t scroll,
    input  word_t        scr0_data,
    input  word_t        scr1_data,
    input  word_t        scr2_data,
    input  word_t        spr_data,
    input  logic         hsync,
    input  logic         vsync,
    input  logic         fblank,
    input  logic         vint,
    input  logic         chk_valid,
    input  logic [3:0]   chk_kind,
    input  word_t        chk_sel,
    input  word_t        chk_exp,
    input  logic         report,
    output int           checks,
    output int           errors
);

    logic [127:0] scroll_flat;
    word_t        rd_exp;
    int           rd_age;

    assign scroll_flat = scroll;

    initial begin
        checks = 0;
        errors = 0;
        rd_age = -1;
    end

    // bg_x sits in the top bits of the struct
    function automatic word_t scroll_field(input logic [2:0] idx);
        return scroll_flat[127 - 16*idx -: 16];
    endfunction

    function automatic string field_name(input logic [2:0] idx);
        case (idx)
            3'd0: return "scroll.bg_x";
            3'd1: return "scroll.bg_y";
            3'd2: return "scroll.fg_x";
            3'd3: return "scroll.fg_y";
            3'd4: return "scroll.txt_x";
            3'd5: return "scroll.txt_y";
            3'd6: return "scroll.spr_x";
            default: return "scroll.spr_y";
        endcase
    endfunction

    task automatic compare(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, act);
        end else begin
            $display("ok  %s = %h", name, act);
        end
    endtask

    always @(posedge CLK96) begin
        if (!RESET96) begin
            // edges since the read was accepted
            if (rd_age >= 0) begin
                rd_age++;
            end
            if (rsp.valid) begin
                if (rd_age < 0) begin
                    checks++;
                    errors++;
                    $display("response pulse seen with no read in flight");
                end else begin
                    compare("rsp.data", rd_exp, rsp.data);
                    compare("rsp.valid latency", 16'd3, 16'(rd_age));
                    rd_age = -1;
                end
            end
            if (cmd_valid && cmd_ready &&
                (cmd.op == OP_READ_RAM_H || cmd.op == OP_READ_RAM_L)) begin
                rd_age = 0;
            end
            if (chk_valid) begin
                case (chk_kind)
                    4'h5, 4'h6: rd_exp = chk_exp;
                    4'h7: compare(field_name(chk_sel[2:0]), chk_exp, scroll_field(chk_sel[2:0]));
                    4'h8: begin
                        case (chk_sel[1:0])
                            2'd0: compare("scr0_data", chk_exp, scr0_data);
                            2'd1: compare("scr1_data", chk_exp, scr1_data);
                            2'd2: compare("scr2_data", chk_exp, scr2_data);
                            default: compare("spr_data", chk_exp, spr_data);
                        endcase
                    end
                    4'h9: compare("{vint,fblank,vsync,hsync}", chk_exp,
                                  {12'h000, vint, fblank, vsync, hsync});
                    default: begin
                        errors++;
                        $display("unknown check kind %h requested", chk_kind);
                    end
                endcase
            end
            if (report) begin
                if (rd_age >= 0) begin
                    errors++;
                    $display("a read was still waiting for its response at the end");
                end
                $display("checks %0d, errors %0d", checks, errors);
            end
        end
    end

endmodule

//--- dv/gcu_tb.sv
`timescale 1ns/1ps

module gcu_tb
    import gcu_bus_pkg::*;
    import vram_map_pkg::*;
();

    logic         CLK96;
    logic         RESET96;
    gcu_cmd_t     cmd;
    logic         cmd_valid;
    logic         cmd_ready;
    gcu_rsp_t     rsp;
    scroll_regs_t scroll;
    layer_addr_t  scr0_addr, scr1_addr, scr2_addr;
    word_t        scr0_data, scr1_data, scr2_data;
    sprite_addr_t spr_addr;
    word_t        spr_data;
    pos_t         h, v, hs_start, hs_end, vs_start, vs_end;
    logic         hsync, vsync, fblank, vint;
    logic         chk_valid;
    logic [3:0]   chk_kind;
    word_t        chk_sel;
    word_t        chk_exp;
    logic         report;
    int           checks;
    int           errors;
    word_t        stim [0:255];

    gcu_top UUT (.*);

    gcu_checker u_checker (.*);

    initial begin
        CLK96 = 1'b0;
        forever #5 CLK96 = ~CLK96;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!cmd_ready) begin
            @(posedge CLK96);
            #1;
            cycles++;
            if (cycles >= 50) begin
                fail_run("timeout: cmd_ready stayed low for 50 cycles");
            end
        end
    endtask

    task automatic wait_rsp();
        int cycles;
        cycles = 0;
        while (!rsp.valid) begin
            @(posedge CLK96);
            #1;
            cycles++;
            if (cycles >= 50) begin
                fail_run("timeout: no read response within 50 cycles");
            end
        end
        // let the checker sample the pulse
        @(posedge CLK96);
        #1;
    endtask

    task automatic post_check(input logic [3:0] kind, input word_t sel, input word_t exp);
        chk_valid = 1'b1;
        chk_kind  = kind;
        chk_sel   = sel;
        chk_exp   = exp;
        @(posedge CLK96);
        #1;
        chk_valid = 1'b0;
    endtask

    task automatic send_cmd(input gcu_op_e op, input word_t data);
        repeat ($urandom % 3) begin
            @(posedge CLK96);
            #1;
        end
        cmd.op    = op;
        cmd.data  = data;
        cmd_valid = 1'b1;
        wait_ready();
        // accepting edge
        @(posedge CLK96);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic run_line(input word_t act, input word_t a, input word_t b, input word_t exp);
        case (act)
            16'h1: send_cmd(OP_SELECT_REG, a);
            16'h2: send_cmd(OP_WRITE_REG, a);
            16'h3: send_cmd(OP_SET_PTR, a);
            16'h4: begin
                send_cmd(OP_WRITE_RAM, a);
                wait_ready();
            end
            16'h5, 16'h6: begin
                // checker learns the expected data before the read goes out
                post_check(act[3:0], a, exp);
                send_cmd(act == 16'h5 ? OP_READ_RAM_H : OP_READ_RAM_L, a);
                wait_rsp();
            end
            16'h7: post_check(act[3:0], a, exp);
            16'h8: begin
                case (a[1:0])
                    2'd0: scr0_addr = b[LAYER_AW-1:0];
                    2'd1: scr1_addr = b[LAYER_AW-1:0];
                    2'd2: scr2_addr = b[LAYER_AW-1:0];
                    default: spr_addr = b[SPRITE_AW-1:0];
                endcase
                @(posedge CLK96);
                #1;
                post_check(act[3:0], a, exp);
            end
            16'h9: begin
                h = a[8:0];
                v = b[8:0];
                // outputs lag by one register stage
                @(posedge CLK96);
                #1;
                post_check(act[3:0], a, exp);
            end
            default: fail_run($sformatf("unknown stimulus action %h", act));
        endcase
    endtask

    initial begin
        int idx;
        void'($urandom(32'hdbcc));
        RESET96   = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;
        scr0_addr = '0;
        scr1_addr = '0;
        scr2_addr = '0;
        spr_addr  = '0;
        h         = '0;
        v         = '0;
        hs_start  = 9'h020;
        hs_end    = 9'h040;
        vs_start  = 9'h0F0;
        vs_end    = 9'h0F8;
        chk_valid = 1'b0;
        chk_kind  = '0;
        chk_sel   = '0;
        chk_exp   = '0;
        report    = 1'b0;
        $readmemh("dv/gcu_stimulus.txt", stim);
        repeat (8) @(posedge CLK96);
        #1;
        RESET96 = 1'b0;
        idx = 0;
        // four words per line, action 0 ends the list
        while (idx < 253 && !$isunknown(stim[idx]) && stim[idx] != 16'h0000) begin
            run_line(stim[idx], stim[idx+1], stim[idx+2], stim[idx+3]);
            idx += 4;
        end
        // layer 2 mirror, written through main VRAM at 0x1005
        run_line(16'h3, 16'h1005, 16'h0000, 16'h0000);
        run_line(16'h4, 16'hC0DE, 16'h0000, 16'h0000);
        run_line(16'h8, 16'h0002, 16'h0005, 16'hC0DE);
        // index 0x0E must not fall through to spr_x
        run_line(16'h7, 16'h0006, 16'h0000, 16'h0000);
        report = 1'b1;
        @(posedge CLK96);
        #1;
        report = 1'b0;
        if (errors == 0 && checks > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dv/gcu_stimulus.txt
// action a b expected, action 0 ends the list
// 1 sel 2 wreg 3 ptr 4 wram 5 rd_h 6 rd_l 7 scroll field 8 render port addr 9 h v {vint,fblank,vsync,hsync}
1 0002 0000 0000
2 1234 0000 0000
7 0002 0000 1234
1 0087 0000 0000
2 BEEF 0000 0000
7 0007 0000 BEEF
1 000E 0000 0000
2 5A5A 0000 0000
7 0002 0000 1234
7 0007 0000 BEEF
7 0000 0000 0000
3 0800 0000 0000
4 AAAA 0000 0000
4 5555 0000 0000
3 0800 0000 0000
5 0000 0000 AAAA
6 0000 0000 5555
8 0001 0000 AAAA
3 0001 0000 0000
4 1111 0000 0000
3 1801 0000 0000
4 7E57 0000 0000
8 0003 0001 7E57
8 0000 0001 1111
1 0003 0000 0000
9 0020 0000 000F
9 0021 0000 000A
9 003F 0000 000A
9 0040 0000 000F
9 0000 00F0 0009
9 0000 00F8 0009
9 0000 00F9 000F
9 0030 00F4 0008
9 0000 00E6 0007
9 0000 0000 000F
1 000F 0000 0000
9 0000 0000 0007
1 008F 0000 0000
9 0000 0000 0007
1 0003 0000 0000
9 0000 0000 000F
0 0000 0000 0000

//--- verilog.f
hdl/gcu_bus_pkg.sv
hdl/vram_map_pkg.sv
hdl/gcu_dpram.sv
hdl/gcu_bus_ctrl.sv
hdl/vram_banks.sv
hdl/video_timing.sv
hdl/gcu_top.sv
dv/gcu_checker.sv
dv/gcu_tb.sv
